// ==== source/tetris_pkg.sv ====
package tetris_pkg;

    ////////////////////////////////////////////////////////////
    // Board geometry
    ////////////////////////////////////////////////////////////

    localparam int ROWS        = 22;
    localparam int COLS        = 10;

    // Rows 0 and 1 are the spawn area above the visible field
    localparam int HIDDEN_ROWS = 2;

    // Colour code per cell, zero is an empty cell
    typedef logic [2:0] cell_t;

    typedef cell_t [COLS-1:0] row_t;

    // Row 0 is the top of the field, row 21 the bottom
    typedef row_t [ROWS-1:0] grid_t;

    typedef struct packed {
        logic [4:0] row;
        logic [3:0] col;
    } coord_t;

    // Falling piece as handed over at lock time
    typedef struct packed {
        cell_t        color;
        coord_t [3:0] cells;
    } piece_t;

    ////////////////////////////////////////////////////////////
    // Scoring
    ////////////////////////////////////////////////////////////

    typedef logic [23:0] score_t;
    typedef logic [15:0] lines_t;
    typedef logic [3:0]  level_t;

    // Base points per clear pass, scaled by level + 1
    localparam score_t SCORE_1 = 24'd100;
    localparam score_t SCORE_2 = 24'd300;
    localparam score_t SCORE_3 = 24'd500;
    localparam score_t SCORE_4 = 24'd800;

endpackage

// ==== source/piece_lock.sv ====
`timescale 1ns/1ps

module piece_lock import tetris_pkg::*; (
    input  grid_t  board_i,
    input  piece_t piece_i,
    output grid_t  merged_o,
    output logic   illegal_o
);

    // One flag per piece cell for each kind of violation
    logic [3:0] off_board;
    logic [3:0] occupied;
    logic [3:0] in_hidden;
    logic [3:0] repeated;

    ////////////////////////////////////////////////////////////
    // Placement checks
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            off_board[i] = (piece_i.cells[i].row >= ROWS) ||
                           (piece_i.cells[i].col >= COLS);

            in_hidden[i] = piece_i.cells[i].row < HIDDEN_ROWS;

            // Only look the cell up when the address is on the board
            occupied[i] = 1'b0;
            if (!off_board[i]) begin
                occupied[i] = board_i[piece_i.cells[i].row][piece_i.cells[i].col] != '0;
            end

            // Compare against every earlier cell of the same piece
            repeated[i] = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (piece_i.cells[j] == piece_i.cells[i]) begin
                    repeated[i] = 1'b1;
                end
            end
        end
    end

    assign illegal_o = (piece_i.color == '0) ||
                       (|off_board) ||
                       (|occupied)  ||
                       (|in_hidden) ||
                       (|repeated);

    ////////////////////////////////////////////////////////////
    // Merge
    ////////////////////////////////////////////////////////////

    // The merged board is only written back when the placement is legal
    always_comb begin
        merged_o = board_i;
        for (int i = 0; i < 4; i++) begin
            if (!off_board[i]) begin
                merged_o[piece_i.cells[i].row][piece_i.cells[i].col] = piece_i.color;
            end
        end
    end

endmodule

// ==== source/line_clear.sv ====
`timescale 1ns/1ps

module line_clear import tetris_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  grid_t      grid_i,
    output grid_t      grid_o,
    output logic [2:0] cleared_o,
    output logic       done_o
);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        SHIFT,
        DONE
    } clear_state_t;

    clear_state_t state;

    // Working copy of the board, rewritten in place
    grid_t        work;

    logic [4:0]   row_idx;
    logic [3:0]   col_idx;
    logic [4:0]   shift_idx;
    logic         row_full;
    logic [2:0]   cleared;

    logic         cell_empty;
    logic         row_end;
    logic         full_now;

    assign cell_empty = work[row_idx][col_idx] == '0;
    assign row_end    = col_idx == 4'(COLS - 1);

    // Row is still full including the cell checked this cycle
    assign full_now   = row_full && !cell_empty;

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            row_idx   <= '0;
            col_idx   <= '0;
            shift_idx <= '0;
            row_full  <= 1'b1;
            cleared   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        row_idx  <= 5'(ROWS - 1);
                        col_idx  <= '0;
                        row_full <= 1'b1;
                        cleared  <= '0;
                        state    <= SCAN;
                    end
                end

                // One cell per clock, left to right
                SCAN: begin
                    if (row_end) begin
                        col_idx  <= '0;
                        row_full <= 1'b1;
                        if (full_now) begin
                            shift_idx <= row_idx;
                            state     <= SHIFT;
                        end else if (row_idx == '0) begin
                            state <= DONE;
                        end else begin
                            row_idx <= row_idx - 5'd1;
                        end
                    end else begin
                        col_idx  <= col_idx + 4'd1;
                        row_full <= full_now;
                    end
                end

                // Walk up from the full row, then blank row 0
                SHIFT: begin
                    if (shift_idx == '0) begin
                        if (cleared != '1) begin
                            cleared <= cleared + 3'd1;
                        end
                        // Same index again, new contents dropped into it
                        state <= SCAN;
                    end else begin
                        shift_idx <= shift_idx - 5'd1;
                    end
                end

                DONE: begin
                    state <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Working grid
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            work <= grid_i;
        end else if (state == SHIFT) begin
            if (shift_idx == '0) begin
                work[0] <= '0;
            end else begin
                work[shift_idx] <= work[shift_idx - 5'd1];
            end
        end
    end

    assign grid_o    = work;
    assign cleared_o = cleared;

    // High for the single cycle after the last scan of row 0
    assign done_o    = state == DONE;

endmodule

// ==== source/line_score.sv ====
`timescale 1ns/1ps

module line_score import tetris_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       done_i,
    input  logic [2:0] cleared_i,
    output lines_t     lines_o,
    output level_t     level_o,
    output score_t     score_o
);

    lines_t      lines_q;
    score_t      score_q;
    score_t      base;
    logic [4:0]  mult;
    score_t      points;
    logic [24:0] sum;

    // Base points for the number of lines in one pass
    always_comb begin
        case (cleared_i)
            3'd1:    base = SCORE_1;
            3'd2:    base = SCORE_2;
            3'd3:    base = SCORE_3;
            default: base = SCORE_4;
        endcase
    end

    // Level is a tenth of the lines, topping out at 15
    assign level_o = (lines_q >= 16'd150) ? 4'd15 : level_t'(lines_q / 16'd10);

    // Multiplier uses the level from before this pass
    assign mult   = {1'b0, level_o} + 5'd1;
    assign points = base * score_t'(mult);
    assign sum    = {1'b0, score_q} + {1'b0, points};

    ////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lines_q <= '0;
            score_q <= '0;
        end else if (done_i && cleared_i != '0) begin
            // Carry out of the adder pins the score at its maximum
            score_q <= sum[24] ? '1 : sum[23:0];
            lines_q <= lines_q + lines_t'(cleared_i);
        end
    end

    assign lines_o = lines_q;
    assign score_o = score_q;

endmodule

// ==== source/playfield_top.sv ====
`timescale 1ns/1ps

module playfield_top import tetris_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   lock_i,
    input  piece_t piece_i,
    output grid_t  board_o,
    output logic   busy_o,
    output logic   game_over_o,
    output logic   clear_done_o,
    output lines_t lines_o,
    output level_t level_o,
    output score_t score_o
);

    grid_t      board_q;
    grid_t      merged;
    logic       illegal;

    logic       busy_q;
    logic       game_over_q;
    logic       start_q;
    logic       clear_done_q;

    grid_t      clear_grid;
    logic [2:0] cleared;
    logic       clear_done;

    logic       accept;

    // Locks are dropped while a clear runs or after the game ended
    assign accept = lock_i && !busy_q && !game_over_q;

    ////////////////////////////////////////////////////////////
    // Sub blocks
    ////////////////////////////////////////////////////////////

    piece_lock u_piece_lock (
        .board_i   (board_q),
        .piece_i   (piece_i),
        .merged_o  (merged),
        .illegal_o (illegal)
    );

    line_clear u_line_clear (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start_q),
        .grid_i    (board_q),
        .grid_o    (clear_grid),
        .cleared_o (cleared),
        .done_o    (clear_done)
    );

    line_score u_line_score (
        .clk       (clk),
        .rst       (rst),
        .done_i    (clear_done),
        .cleared_i (cleared),
        .lines_o   (lines_o),
        .level_o   (level_o),
        .score_o   (score_o)
    );

    ////////////////////////////////////////////////////////////
    // Board and sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            board_q      <= '0;
            busy_q       <= 1'b0;
            game_over_q  <= 1'b0;
            start_q      <= 1'b0;
            clear_done_q <= 1'b0;
        end else begin
            start_q      <= 1'b0;
            clear_done_q <= clear_done;

            if (accept) begin
                if (illegal) begin
                    game_over_q <= 1'b1;
                end else begin
                    board_q <= merged;
                    busy_q  <= 1'b1;
                    start_q <= 1'b1;
                end
            end

            // Cleared board lands together with the score update
            if (clear_done) begin
                board_q <= clear_grid;
                busy_q  <= 1'b0;
            end
        end
    end

    assign board_o      = board_q;
    assign busy_o       = busy_q;
    assign game_over_o  = game_over_q;
    assign clear_done_o = clear_done_q;

endmodule

// ==== bench/playfield_assert.sv ====
`timescale 1ns/1ps

module playfield_assert import tetris_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  lock_i,
    input logic  busy_o,
    input logic  game_over_o,
    input logic  clear_done_o,
    input grid_t board_o
);

    // Not busy in the first cycle out of reset
    assert property (@(posedge clk) rst |=> !busy_o)
        else $error("busy_o high right after reset");

    assert property (@(posedge clk) disable iff (rst) clear_done_o |=> !clear_done_o)
        else $error("clear_done_o high for two cycles");

    // Idle board only changes through an accepted lock
    assert property (@(posedge clk) disable iff (rst)
        (!busy_o && (!lock_i || game_over_o)) |=> $stable(board_o))
        else $error("board_o changed while idle");

    assert property (@(posedge clk) disable iff (rst) !$fell(game_over_o))
        else $error("game_over_o fell without reset");

endmodule

bind playfield_top playfield_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .lock_i       (lock_i),
    .busy_o       (busy_o),
    .game_over_o  (game_over_o),
    .clear_done_o (clear_done_o),
    .board_o      (board_o)
);

// ==== bench/playfield_model.svh ====
`ifndef PLAYFIELD_MODEL_SVH
`define PLAYFIELD_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference model of the board rules
////////////////////////////////////////////////////////////

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic bit model_illegal(input grid_t b, input piece_t p);
    int r;
    int c;
    bit bad;
    bad = (p.color == 3'd0);
    for (int i = 0; i < 4; i++) begin
        r = int'(p.cells[i].row);
        c = int'(p.cells[i].col);
        if (r >= 22 || c >= 10 || r < 2) begin
            bad = 1'b1;
        end else if (b[r][c] != 3'd0) begin
            bad = 1'b1;
        end
        for (int j = 0; j < i; j++) begin
            if (p.cells[j].row == p.cells[i].row && p.cells[j].col == p.cells[i].col) begin
                bad = 1'b1;
            end
        end
    end
    return bad;
endfunction

function automatic grid_t model_merge(input grid_t b, input piece_t p);
    grid_t m;
    m = b;
    for (int i = 0; i < 4; i++) begin
        m[int'(p.cells[i].row)][int'(p.cells[i].col)] = p.color;
    end
    return m;
endfunction

// Collects the rows that are not full from the bottom up
function automatic grid_t model_clear(input grid_t b, output int n);
    grid_t r;
    int dst;
    bit full;
    r = '0;
    dst = 21;
    n = 0;
    for (int src = 21; src >= 0; src--) begin
        full = 1'b1;
        for (int c = 0; c < 10; c++) begin
            if (b[src][c] == 3'd0) full = 1'b0;
        end
        if (full) begin
            n++;
        end else begin
            r[dst] = b[src];
            dst--;
        end
    end
    return r;
endfunction

function automatic level_t model_level(input lines_t l);
    int lv;
    lv = int'(l) / 10;
    if (lv > 15) lv = 15;
    return level_t'(lv);
endfunction

function automatic score_t model_score(input score_t s, input lines_t l, input int n);
    longint base;
    longint total;
    case (n)
        1:       base = 100;
        2:       base = 300;
        3:       base = 500;
        default: base = 800;
    endcase
    if (n == 0) return s;
    total = longint'(s) + base * (longint'(model_level(l)) + 1);
    if (total > 64'hFFFFFF) total = 64'hFFFFFF;
    return score_t'(total);
endfunction

`endif

// ==== bench/playfield_tb.sv ====
`timescale 1ns/1ps

module playfield_tb import tetris_pkg::*; ();

    localparam int TIMEOUT = 3000;

    logic   clk;
    logic   rst;
    logic   lock_i;
    piece_t piece_i;
    grid_t  board_o;
    logic   busy_o;
    logic   game_over_o;
    logic   clear_done_o;
    lines_t lines_o;
    level_t level_o;
    score_t score_o;

    // Model state
    grid_t       model_board;
    lines_t      model_lines;
    score_t      model_score_q;
    bit          model_over;
    logic [31:0] rng_state;

    int errors;
    int tests_run;
    int tests_failed;
    int test_start_errors;

    `include "playfield_model.svh"

    playfield_top uut (
        .clk          (clk),
        .rst          (rst),
        .lock_i       (lock_i),
        .piece_i      (piece_i),
        .board_o      (board_o),
        .busy_o       (busy_o),
        .game_over_o  (game_over_o),
        .clear_done_o (clear_done_o),
        .lines_o      (lines_o),
        .level_o      (level_o),
        .score_o      (score_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check(input string name, input logic [659:0] got, input logic [659:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_all();
        check("board_o", board_o, model_board);
        check("lines_o", 660'(lines_o), 660'(model_lines));
        check("level_o", 660'(level_o), 660'(model_level(model_lines)));
        check("score_o", 660'(score_o), 660'(model_score_q));
        check("busy_o", 660'(busy_o), 660'(0));
        check("game_over_o", 660'(game_over_o), 660'(model_over));
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            $display("Test %0d %s: FAIL", tests_run, name);
            tests_failed++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst = 1'b1;
        lock_i = 1'b0;
        piece_i = '0;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        model_board = '0;
        model_lines = '0;
        model_score_q = '0;
        model_over = 1'b0;
    endtask

    // One-cycle lock strobe, accepted at the second edge
    task automatic drive_lock(input piece_t p);
        @(posedge clk);
        #2;
        lock_i = 1'b1;
        piece_i = p;
        @(posedge clk);
        #2 lock_i = 1'b0;
    endtask

    task automatic wait_clear_done();
        int n;
        n = 0;
        while (n < TIMEOUT) begin
            @(negedge clk);
            if (clear_done_o) break;
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timeout while waiting for clear_done_o");
            errors++;
        end
    endtask

    task automatic wait_game_over();
        int n;
        n = 0;
        while (n < 20 && !game_over_o) begin
            @(negedge clk);
            n++;
        end
        if (!game_over_o) begin
            $display("Illegal piece did not raise game_over_o");
            errors++;
        end
    endtask

    task automatic model_apply(input piece_t p);
        int n;
        model_board = model_clear(model_merge(model_board, p), n);
        model_score_q = model_score(model_score_q, model_lines, n);
        model_lines = model_lines + lines_t'(n);
    endtask

    task automatic lock_and_check(input piece_t p);
        model_apply(p);
        drive_lock(p);
        wait_clear_done();
        check_all();
    endtask

    // Random piece, mostly in the low rows so rows tend to fill up
    task automatic gen_piece(output piece_t p);
        grid_t       tmp;
        logic [31:0] v;
        int          r;
        int          col;
        int          start;
        int          tries;
        bit          found;
        tmp = model_board;
        p = '0;
        for (int k = 0; k < 4; k++) begin
            found = 1'b0;
            tries = 0;
            while (!found && tries < 64) begin
                v = next_rand();
                if (v[2:0] < 3'd5) r = 21 - int'(v[7:4]) % 4;
                else r = 12 + int'(v[11:8]) % 10;
                start = int'(v[19:16]) % 10;
                for (int c = 0; c < 10 && !found; c++) begin
                    col = (start + c) % 10;
                    if (tmp[r][col] == 3'd0) begin
                        found = 1'b1;
                    end
                end
                tries++;
            end
            // Fall back to any free visible cell
            for (int rr = 21; rr >= 2 && !found; rr--) begin
                for (int c = 0; c < 10 && !found; c++) begin
                    if (tmp[rr][c] == 3'd0) begin
                        r = rr;
                        col = c;
                        found = 1'b1;
                    end
                end
            end
            p.cells[k].row = 5'(r);
            p.cells[k].col = 4'(col);
            tmp[r][col] = 3'd7;
        end
        p.color = 3'(1 + int'(next_rand() % 7));
        if (model_illegal(model_board, p)) begin
            $display("Random generator could not place a legal piece");
            errors++;
        end
    endtask

    function automatic piece_t column_piece(input int col, input int top, input int color);
        piece_t p;
        p.color = 3'(color);
        for (int i = 0; i < 4; i++) begin
            p.cells[i].row = 5'(top + i);
            p.cells[i].col = 4'(col);
        end
        return p;
    endfunction

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        piece_t p;
        piece_t q;
        grid_t  saved;
        row_t   row17;
        int     locks;
        int     n;
        bit     found;

        clk = 1'b0;
        rst = 1'b1;
        lock_i = 1'b0;
        piece_i = '0;
        rng_state = 32'd8604;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;

        begin_test();
        apply_reset();
        @(negedge clk);
        check_all();
        check("clear_done_o", 660'(clear_done_o), 660'(0));
        end_test("reset state");

        begin_test();
        for (int i = 0; i < 30; i++) begin
            gen_piece(p);
            lock_and_check(p);
        end
        end_test("random locks");

        begin_test();
        locks = 0;
        while (model_lines <= 16'd20 && locks < 600) begin
            gen_piece(p);
            lock_and_check(p);
            locks++;
        end
        if (model_lines <= 16'd20) begin
            $display("Long run did not clear more than 20 lines");
            errors++;
        end
        end_test("long random run");

        begin_test();
        apply_reset();
        for (int k = 0; k < 9; k++) begin
            lock_and_check(column_piece(k, 18, k % 7 + 1));
        end
        // Row 17 content that should drop to the bottom
        p.color = 3'd5;
        for (int i = 0; i < 4; i++) begin
            p.cells[i].row = 5'd17;
            p.cells[i].col = 4'(i);
        end
        lock_and_check(p);
        row17 = model_board[17];
        lock_and_check(column_piece(9, 18, 2));
        check("lines_o", 660'(lines_o), 660'(16'd4));
        check("score_o", 660'(score_o), 660'(24'd800));
        check("level_o", 660'(level_o), 660'(4'd0));
        check("board_o[21]", 660'(board_o[21]), 660'(row17));
        check("board_o[17]", 660'(board_o[17]), 660'(0));
        end_test("four line clear");

        begin_test();
        gen_piece(p);
        model_apply(p);
        gen_piece(q);
        @(posedge clk);
        #2;
        lock_i = 1'b1;
        piece_i = p;
        @(posedge clk);
        #2 piece_i = q;
        check("busy_o", 660'(busy_o), 660'(1));
        @(posedge clk);
        #2 lock_i = 1'b0;
        wait_clear_done();
        check_all();
        end_test("lock while busy");

        begin_test();
        found = 1'b0;
        gen_piece(p);
        for (int r = 21; r >= 2 && !found; r--) begin
            for (int c = 0; c < 10 && !found; c++) begin
                if (model_board[r][c] != 3'd0) begin
                    p.cells[0].row = 5'(r);
                    p.cells[0].col = 4'(c);
                    found = 1'b1;
                end
            end
        end
        if (!found) begin
            $display("No occupied cell found for the overlap test");
            errors++;
        end
        saved = model_board;
        drive_lock(p);
        wait_game_over();
        model_over = 1'b1;
        check_all();
        // Later locks must be ignored
        gen_piece(q);
        drive_lock(q);
        n = 0;
        while (n < 40) begin
            @(negedge clk);
            if (busy_o) begin
                $display("Lock accepted after game over");
                errors++;
                break;
            end
            n++;
        end
        check("board_o", board_o, saved);
        end_test("overlap game over");

        begin_test();
        apply_reset();
        p.color = 3'd3;
        for (int i = 0; i < 4; i++) begin
            p.cells[i].row = 5'd1;
            p.cells[i].col = 4'(3 + i);
        end
        drive_lock(p);
        wait_game_over();
        model_over = 1'b1;
        check_all();
        end_test("hidden row game over");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+bench
source/tetris_pkg.sv
source/piece_lock.sv
source/line_clear.sv
source/line_score.sv
source/playfield_top.sv
bench/playfield_assert.sv
bench/playfield_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = playfield_tb
FILELIST  = compile.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation completed successfully$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
